// File: Makefile
TOP = control_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -qF '** FAIL **' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '** PASS **' sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: verification/control_unit_tb.sv
`timescale 1ns/10ps

module control_unit_tb
    import cu_pkg::*;
();

    localparam int MAX_TRACE = 20;

    logic        clk;
    logic        reset;
    instr_word_t instr;
    logic        ov;
    ctrl_word_t  ctrl;

    string       pat_name[$];
    logic [31:0] pat_instr[$];
    logic        pat_ov[$];
    string       pat_tag[$];
    int          pat_cycles[$];

    // Observed and expected ctrl words of one instruction
    ctrl_word_t  got_q[$];
    ctrl_word_t  exp_q[$];
    ctrl_word_t  last_sample;

    int          checks;
    int          errors;
    bit          loaded;

    control_unit control_unit_inst (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .ov    (ov),
        .ctrl  (ctrl)
    );

    always begin
        #2 clk = ~clk;
    end

    function automatic ctrl_word_t stack_init_word();
        ctrl_word_t w;
        w = CTRL_IDLE;
        w.reg_write  = 1'b1;
        w.reg_dst    = DST_SP;
        w.mem_to_reg = WB_STACK_TOP;
        return w;
    endfunction

    function automatic ctrl_word_t fetch_wait_word();
        ctrl_word_t w;
        w = CTRL_IDLE;
        w.iord      = ADDR_PC;
        w.alu_src_a = SRCA_PC;
        w.alu_src_b = SRCB_FOUR;
        w.alu_op    = ALU_ADD;
        return w;
    endfunction

    function automatic ctrl_word_t fetch_word();
        ctrl_word_t w;
        w = fetch_wait_word();
        w.pc_write = 1'b1;
        w.ir_write = 1'b1;
        w.mem_wr   = 1'b1;
        return w;
    endfunction

    function automatic ctrl_word_t decode_word();
        ctrl_word_t w;
        w = fetch_word();
        w.a_write = 1'b1;
        w.b_write = 1'b1;
        return w;
    endfunction

    function automatic ctrl_word_t exec_word(instr_class_t c);
        ctrl_word_t w;
        w = CTRL_IDLE;
        w.alu_src_a     = SRCA_A;
        w.alu_out_write = 1'b1;
        w.alu_src_b     = (c inside {CLS_ADD, CLS_AND, CLS_SUB}) ? SRCB_B : SRCB_IMM;
        if (c == CLS_AND) begin
            w.alu_op = ALU_AND;
        end else if (c == CLS_SUB) begin
            w.alu_op = ALU_SUB;
        end else begin
            w.alu_op = ALU_ADD;
        end
        return w;
    endfunction

    function automatic ctrl_word_t writeback_word(instr_class_t c, logic ovf);
        ctrl_word_t w;
        w = CTRL_IDLE;
        if (!ovf) begin
            w.reg_write  = 1'b1;
            w.reg_dst    = (c inside {CLS_ADD, CLS_AND, CLS_SUB}) ? DST_RD : DST_RT;
            w.mem_to_reg = WB_ALU;
        end
        return w;
    endfunction

    function automatic ctrl_word_t exc_wait_word(cause_t c);
        ctrl_word_t w;
        w = CTRL_IDLE;
        w.cause = c;
        w.iord  = ADDR_VECTOR;
        return w;
    endfunction

    function automatic ctrl_word_t exc_enter_word(cause_t c);
        ctrl_word_t w;
        w = CTRL_IDLE;
        w.epc_write = 1'b1;
        w.pc_write  = 1'b1;
        w.pc_src    = PC_VECTOR;
        w.cause     = c;
        return w;
    endfunction

    function automatic instr_class_t class_from_tag(string tag);
        if (tag == "add") begin
            return CLS_ADD;
        end else if (tag == "and") begin
            return CLS_AND;
        end else if (tag == "sub") begin
            return CLS_SUB;
        end else if (tag == "addi") begin
            return CLS_ADDI;
        end else if (tag == "addiu") begin
            return CLS_ADDIU;
        end
        return CLS_UNDEF;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        int          ovv;
        int          cyc;
        string       line;
        string       name;
        string       tag;
        logic [31:0] word;
        fd = $fopen("verification/cu_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open verification/cu_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %h %d %s %d", name, word, ovv, tag, cyc);
            if (n != 5) begin
                $display("ERROR: malformed pattern line: %s", line);
                errors++;
            end else if (tag != "undef" && class_from_tag(tag) == CLS_UNDEF) begin
                $display("ERROR: pattern %s has an unknown class tag %s", name, tag);
                errors++;
            end else begin
                pat_name.push_back(name);
                pat_instr.push_back(word);
                pat_ov.push_back(ovv != 0);
                pat_tag.push_back(tag);
                pat_cycles.push_back(cyc);
            end
        end
        $fclose(fd);
    endtask

    task automatic build_expected(input instr_class_t c, input logic ovf);
        exp_q.delete();
        repeat (FETCH_WAIT) exp_q.push_back(fetch_wait_word());
        exp_q.push_back(fetch_word());
        exp_q.push_back(decode_word());
        exp_q.push_back(CTRL_IDLE);
        if (c == CLS_UNDEF) begin
            repeat (EXC_WAIT) exp_q.push_back(exc_wait_word(CAUSE_UNDEF));
            exp_q.push_back(exc_enter_word(CAUSE_UNDEF));
        end else begin
            exp_q.push_back(exec_word(c));
            exp_q.push_back(writeback_word(c, ovf));
            if (ovf) begin
                repeat (EXC_WAIT) exp_q.push_back(exc_wait_word(CAUSE_OVF));
                exp_q.push_back(exc_enter_word(CAUSE_OVF));
            end
        end
    endtask

    task automatic apply_reset();
        int k;
        for (k = 0; k < 5; k++) begin
            @(posedge clk);
            if (k == 4) begin
                reset <= 1'b0;
            end
            @(negedge clk);
            check_value($sformatf("reset cycle %0d", k + 1), 64'(stack_init_word()), 64'(ctrl));
        end
        // Stack-top write lasts one more cycle
        @(posedge clk);
        @(negedge clk);
        check_value("reset release", 64'(stack_init_word()), 64'(ctrl));
        @(posedge clk);
        @(negedge clk);
        last_sample = ctrl;
    endtask

    // Starts on the first fetch-wait word, ends on the next one
    task automatic run_instr(input int idx);
        ctrl_word_t   prev;
        ctrl_word_t   cur;
        instr_class_t exp_cls;
        logic         ov_next;
        bit           done;
        int           k;
        exp_cls = class_from_tag(pat_tag[idx]);
        got_q.delete();
        got_q.push_back(last_sample);
        prev = last_sample;
        cur  = last_sample;
        done = 1'b0;
        @(posedge clk);
        instr <= instr_word_t'(pat_instr[idx]);
        ov    <= 1'b0;
        while (!done) begin
            @(negedge clk);
            cur = ctrl;
            if (cur == fetch_wait_word() && prev != fetch_wait_word()) begin
                done = 1'b1;
            end else if (got_q.size() >= MAX_TRACE) begin
                $display("ERROR: %s never returned to fetch-wait", pat_name[idx]);
                errors++;
                done = 1'b1;
            end else begin
                got_q.push_back(cur);
                // Idle after decode, so the sequencer reaches write-back next
                ov_next = (cur == CTRL_IDLE && prev.a_write) ? pat_ov[idx] : 1'b0;
                @(posedge clk);
                ov <= ov_next;
            end
            prev = cur;
        end
        last_sample = cur;
        build_expected(exp_cls, pat_ov[idx]);
        if (exp_q.size() != pat_cycles[idx]) begin
            $display("ERROR: cycle count of %s in the pattern file does not fit its class",
                     pat_name[idx]);
            errors++;
        end
        check_value({pat_name[idx], " cycles"}, 64'(pat_cycles[idx]), 64'(got_q.size()));
        check_value({pat_name[idx], " class"}, 64'(exp_cls), 64'(control_unit_inst.cls));
        for (k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
            check_value($sformatf("%s cycle %0d", pat_name[idx], k + 1),
                        64'(exp_q[k]), 64'(got_q[k]));
        end
    endtask

    initial begin : main
        int i;
        clk    = 1'b0;
        reset  = 1'b1;
        instr  = '0;
        ov     = 1'b0;
        checks = 0;
        errors = 0;
        loaded = 1'b0;
        load_patterns();
        loaded = 1'b1;
        apply_reset();
        for (i = 0; i < pat_name.size(); i++) begin
            run_instr(i);
        end
        if (pat_name.size() == 0) begin
            $display("ERROR: no test patterns were loaded");
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Longest instruction is 13 cycles
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = pat_name.size() * 13 + 50;
        repeat (limit) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verification/cu_patterns.txt
# name  instr(hex)  ov  class  cycles
# class is add, and, sub, addi, addiu or undef; cycles from one fetch-wait entry to the next
add_r3_r1_r2      00221820 0 add   8
and_r4_r5_r6      00a62024 0 and   8
sub_r7_r8_r9      01093822 0 sub   8
addi_r2_r1_5      20220005 0 addi  8
addiu_r3_r4_m1    2483ffff 0 addiu 8
add_ovf           00221820 1 add   13
addi_ovf          20220005 1 addi  13
sub_ovf           01093822 1 sub   13
mult_r1_r2        00220018 0 undef 11
lw_r2_4_r1        8c220004 0 undef 11
sw_r2_4_r1        ac220004 0 undef 11
beq_r1_r2         10220004 0 undef 11
j_0x40            08000010 0 undef 11
slt_r3_r1_r2      0022182a 0 undef 11
sll_r2_r2_2       00021080 0 undef 11
addu_r3_r1_r2     00221821 0 undef 11
break             0000000d 0 undef 11
opcode_3f         fc000000 0 undef 11
# mixed sequence
mix_addi          20420001 0 addi  8
mix_add_ovf       00221820 1 add   13
mix_lw            8c220004 0 undef 11
mix_sub           01093822 0 sub   8
mix_and           00a62024 0 and   8
mix_mult          00220018 0 undef 11
mix_addiu         2483ffff 0 addiu 8
mix_addi_ovf      20220005 1 addi  13
mix_add           00221820 0 add   8
mix_opcode_3f     fc000000 0 undef 11

// File: verilog/control_unit.sv
`timescale 1ns/10ps

module control_unit import cu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  instr_word_t instr,
    input  logic        ov,
    output ctrl_word_t  ctrl
);

    cu_state_t    state;
    instr_class_t cls;

    instr_decode instr_decode_inst (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .state (state),
        .cls   (cls)
    );

    cu_sequencer cu_sequencer_inst (
        .clk   (clk),
        .reset (reset),
        .cls   (cls),
        .ov    (ov),
        .state (state)
    );

    // Registered, one cycle behind state
    ctrl_encode ctrl_encode_inst (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .cls   (cls),
        .ov    (ov),
        .ctrl  (ctrl)
    );

endmodule

// File: verilog/ctrl_encode.sv
`timescale 1ns/10ps

module ctrl_encode import cu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  cu_state_t    state,
    input  instr_class_t cls,
    input  logic         ov,
    output ctrl_word_t   ctrl
);

    ctrl_word_t word;

    always_comb begin
        word = CTRL_IDLE;
        case (state)
            ST_STACK_INIT: begin
                word = CTRL_STACK_INIT;
            end
            ST_FETCH_WAIT, ST_FETCH, ST_DECODE: begin
                // PC + 4 while memory is read at PC
                word.iord      = ADDR_PC;
                word.alu_src_a = SRCA_PC;
                word.alu_src_b = SRCB_FOUR;
                word.alu_op    = ALU_ADD;
                if (state != ST_FETCH_WAIT) begin
                    word.pc_write = 1'b1;
                    word.ir_write = 1'b1;
                    word.mem_wr   = 1'b1;
                end
                if (state == ST_DECODE) begin
                    word.a_write = 1'b1;
                    word.b_write = 1'b1;
                end
            end
            ST_EXEC: begin
                word.alu_src_a     = SRCA_A;
                word.alu_src_b     = is_rfmt(cls) ? SRCB_B : SRCB_IMM;
                word.alu_out_write = 1'b1;
                case (cls)
                    CLS_AND: begin
                        word.alu_op = ALU_AND;
                    end
                    CLS_SUB: begin
                        word.alu_op = ALU_SUB;
                    end
                    default: begin
                        word.alu_op = ALU_ADD;
                    end
                endcase
            end
            ST_WB_R, ST_WB_I: begin
                // Overflow suppresses the register write
                if (!ov) begin
                    word.reg_write  = 1'b1;
                    word.reg_dst    = (state == ST_WB_R) ? DST_RD : DST_RT;
                    word.mem_to_reg = WB_ALU;
                end
            end
            ST_EXC_OVF: begin
                word.cause = CAUSE_OVF;
                word.iord  = ADDR_VECTOR;
            end
            ST_EXC_UNDEF: begin
                word.cause = CAUSE_UNDEF;
                word.iord  = ADDR_VECTOR;
            end
            ST_EXC_ENTER: begin
                word.epc_write = 1'b1;
                word.pc_write  = 1'b1;
                word.pc_src    = PC_VECTOR;
                // ctrl still holds the wait-state word here
                word.cause     = ctrl.cause;
            end
            default: begin
                word = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= CTRL_STACK_INIT;
        end else begin
            ctrl <= word;
        end
    end

    epc_with_pc_a: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.epc_write |-> ctrl.pc_write && (ctrl.pc_src == PC_VECTOR)
    );

    // No register write at entry, nor in the write-back slot before the wait
    no_wb_on_exc_a: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.epc_write |-> !ctrl.reg_write && !$past(ctrl.reg_write, EXC_WAIT + 1)
    );

endmodule

// File: verilog/cu_pkg.sv
package cu_pkg;

    // Opcodes and functs handled by the unit
    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] OP_ADDI   = 6'h08;
    localparam logic [5:0] OP_ADDIU  = 6'h09;

    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_SUB = 6'h22;

    // Wait lengths in cycles
    localparam int FETCH_WAIT = 3;
    localparam int EXC_WAIT   = 4;
    localparam int CNT_W      = 3;

    // Same 32 bits, R format or I format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_view;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i_view;
    } instr_word_t;

    typedef enum logic [2:0] {
        CLS_ADD,
        CLS_AND,
        CLS_SUB,
        CLS_ADDI,
        CLS_ADDIU,
        CLS_UNDEF
    } instr_class_t;

    typedef enum logic [3:0] {
        ST_STACK_INIT,
        ST_FETCH_WAIT,
        ST_FETCH,
        ST_DECODE,
        ST_DISPATCH,
        ST_EXEC,
        ST_WB_R,
        ST_WB_I,
        ST_EXC_OVF,
        ST_EXC_UNDEF,
        ST_EXC_ENTER
    } cu_state_t;

    // Datapath select encodings
    typedef enum logic [2:0] {ALU_ADD = 3'b001, ALU_AND = 3'b010, ALU_SUB = 3'b011} alu_op_t;
    typedef enum logic [1:0] {DST_RT = 2'b00, DST_RD = 2'b01, DST_SP = 2'b10} reg_dst_t;
    typedef enum logic [3:0] {WB_ALU = 4'b0000, WB_STACK_TOP = 4'b0100} mem_to_reg_t;
    typedef enum logic [2:0] {ADDR_PC = 3'b000, ADDR_ALU = 3'b001, ADDR_VECTOR = 3'b010} iord_t;
    typedef enum logic [1:0] {SRCA_PC = 2'b00, SRCA_A = 2'b01} alu_src_a_t;
    typedef enum logic [2:0] {SRCB_B = 3'b000, SRCB_FOUR = 3'b001, SRCB_IMM = 3'b010} alu_src_b_t;
    typedef enum logic [2:0] {PC_ALU = 3'b000, PC_VECTOR = 3'b011} pc_src_t;
    typedef enum logic [1:0] {CAUSE_UNDEF = 2'b00, CAUSE_OVF = 2'b01} cause_t;

    typedef struct packed {
        logic        pc_write;
        logic        ir_write;
        logic        a_write;
        logic        b_write;
        logic        mem_wr;
        logic        alu_out_write;
        logic        epc_write;
        logic        reg_write;
        reg_dst_t    reg_dst;
        cause_t      cause;
        alu_src_a_t  alu_src_a;
        alu_src_b_t  alu_src_b;
        alu_op_t     alu_op;
        pc_src_t     pc_src;
        iord_t       iord;
        mem_to_reg_t mem_to_reg;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '0;

    // Stack-top write held through reset
    localparam ctrl_word_t CTRL_STACK_INIT = '{
        pc_write:      1'b0,
        ir_write:      1'b0,
        a_write:       1'b0,
        b_write:       1'b0,
        mem_wr:        1'b0,
        alu_out_write: 1'b0,
        epc_write:     1'b0,
        reg_write:     1'b1,
        reg_dst:       DST_SP,
        cause:         CAUSE_UNDEF,
        alu_src_a:     SRCA_PC,
        alu_src_b:     SRCB_B,
        alu_op:        alu_op_t'(3'b000),
        pc_src:        PC_ALU,
        iord:          ADDR_PC,
        mem_to_reg:    WB_STACK_TOP
    };

    // Register-format classes take B and write rd
    function automatic logic is_rfmt(instr_class_t c);
        return (c == CLS_ADD) || (c == CLS_AND) || (c == CLS_SUB);
    endfunction

endpackage

// File: verilog/cu_sequencer.sv
`timescale 1ns/10ps

module cu_sequencer import cu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  instr_class_t cls,
    input  logic         ov,
    output cu_state_t    state
);

    cu_state_t        state_next;
    logic [CNT_W-1:0] cnt;
    logic             fetch_done;
    logic             exc_done;

    assign fetch_done = (cnt == CNT_W'(FETCH_WAIT - 1));
    assign exc_done   = (cnt == CNT_W'(EXC_WAIT - 1));

    always_comb begin
        state_next = state;
        case (state)
            ST_STACK_INIT: begin
                state_next = ST_FETCH_WAIT;
            end
            ST_FETCH_WAIT: begin
                if (fetch_done) begin
                    state_next = ST_FETCH;
                end
            end
            ST_FETCH: begin
                state_next = ST_DECODE;
            end
            ST_DECODE: begin
                state_next = ST_DISPATCH;
            end
            ST_DISPATCH: begin
                // Class is valid from here on
                if (cls == CLS_UNDEF) begin
                    state_next = ST_EXC_UNDEF;
                end else begin
                    state_next = ST_EXEC;
                end
            end
            ST_EXEC: begin
                if (is_rfmt(cls)) begin
                    state_next = ST_WB_R;
                end else begin
                    state_next = ST_WB_I;
                end
            end
            ST_WB_R, ST_WB_I: begin
                if (ov) begin
                    state_next = ST_EXC_OVF;
                end else begin
                    state_next = ST_FETCH_WAIT;
                end
            end
            ST_EXC_OVF, ST_EXC_UNDEF: begin
                if (exc_done) begin
                    state_next = ST_EXC_ENTER;
                end
            end
            ST_EXC_ENTER: begin
                state_next = ST_FETCH_WAIT;
            end
            default: begin
                state_next = ST_FETCH_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_STACK_INIT;
        end else begin
            state <= state_next;
        end
    end

    // Restarts on every state change
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (state_next != state) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    property exc_wait_bound(cu_state_t s);
        @(posedge clk) disable iff (reset)
        (state == s) && ($past(state) != s) |->
            (state == s) [*EXC_WAIT] ##1 (state == ST_EXC_ENTER);
    endproperty

    state_legal_a: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(state) && state inside {
            ST_STACK_INIT, ST_FETCH_WAIT, ST_FETCH, ST_DECODE, ST_DISPATCH,
            ST_EXEC, ST_WB_R, ST_WB_I, ST_EXC_OVF, ST_EXC_UNDEF, ST_EXC_ENTER
        }
    );

    exc_ovf_wait_a: assert property (exc_wait_bound(ST_EXC_OVF));

    exc_undef_wait_a: assert property (exc_wait_bound(ST_EXC_UNDEF));

    exc_enter_exit_a: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_EXC_ENTER) |=> (state == ST_FETCH_WAIT)
    );

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/10ps

module instr_decode import cu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  instr_word_t  instr,
    input  cu_state_t    state,
    output instr_class_t cls
);

    instr_class_t cls_next;

    always_comb begin
        cls_next = CLS_UNDEF;
        case (instr.i_view.opcode)
            OP_RTYPE: begin
                // Only the funct field picks the R operation
                case (instr.r_view.funct)
                    FUNCT_ADD: begin
                        cls_next = CLS_ADD;
                    end
                    FUNCT_AND: begin
                        cls_next = CLS_AND;
                    end
                    FUNCT_SUB: begin
                        cls_next = CLS_SUB;
                    end
                    default: begin
                        cls_next = CLS_UNDEF;
                    end
                endcase
            end
            OP_ADDI: begin
                cls_next = CLS_ADDI;
            end
            OP_ADDIU: begin
                cls_next = CLS_ADDIU;
            end
            default: begin
                cls_next = CLS_UNDEF;
            end
        endcase
    end

    // Held for the rest of the instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            cls <= CLS_UNDEF;
        end else if (state == ST_DECODE) begin
            cls <= cls_next;
        end
    end

endmodule

// File: vlog.f
verilog/cu_pkg.sv
verilog/instr_decode.sv
verilog/cu_sequencer.sv
verilog/ctrl_encode.sv
verilog/control_unit.sv
verification/control_unit_tb.sv
